// ==== hdl/bg_layer_pkg.sv ====
/* Shared vector types, fetch FSM states and the tile word field
   and pixel phase constants of the background tile layer */

package bg_layer_pkg;

    // ==============================
    // Vector types
    // ==============================

    // Raw beam position from the video timing counters
    typedef logic [8:0]  beam_t;
    // Scroll offset, also used for the scrolled coordinates
    typedef logic [9:0]  scroll_t;
    // Word address into the tile-map RAM
    typedef logic [12:0] tile_idx_t;
    // One tile-map entry, code plus attributes
    typedef logic [31:0] tile_word_t;
    // Byte address into the graphics ROM in SDRAM
    typedef logic [20:0] gfx_addr_t;
    // One pixel row of a tile, one byte per bit plane
    typedef logic [31:0] gfx_row_t;
    // Colour index of one pixel
    typedef logic [3:0]  pix_t;
    // Palette number carried with each tile
    typedef logic [6:0]  pal_t;

    // Graphics fetch FSM, one outstanding ROM request at a time
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT
    } fetch_state_t;

    // ==============================
    // Tile word fields
    // ==============================

    localparam int HFLIP_BIT = 25;
    localparam int VFLIP_BIT = 26;
    localparam int CP8_BIT   = 23;
    localparam int CP15_BIT  = 24;
    // Palette occupies the seven bits from here upwards
    localparam int PAL_LSB   = 16;

    // Pixel phase within a tile where each step happens
    localparam logic [2:0] PH_INDEX = 3'd0;
    localparam logic [2:0] PH_FETCH = 3'd2;
    localparam logic [2:0] PH_LOAD  = 3'd7;

endpackage

// ==== hdl/scroll_counter.sv ====
/* Scrolled beam coordinates, pixel phase with screen flip,
   and the registered tile-map address */

`timescale 1ns/10ps

module scroll_counter (
    input  logic                    CLK_32M,
    input  logic                    rst_n,
    input  logic                    CE_PIX,
    input  logic                    NL,
    input  logic                    wide,
    input  bg_layer_pkg::beam_t     VE,
    input  bg_layer_pkg::beam_t     HE,
    input  bg_layer_pkg::scroll_t   v_adj,
    input  bg_layer_pkg::scroll_t   h_adj,
    output bg_layer_pkg::tile_idx_t tile_index,
    output logic [2:0]              phase,
    output logic [2:0]              row,
    output logic                    code_strobe
);

    import bg_layer_pkg::*;

    // Scrolled vertical and horizontal positions, both wrap at 10 bits
    scroll_t sv;
    scroll_t sh;

    // ==============================
    // Scrolled coordinates
    // ==============================

    assign sv = {1'b0, VE} + v_adj;

    // With the screen flipped the pixels inside a tile run backwards,
    // so only the low three bits of the horizontal sum are inverted
    assign sh = ({1'b0, HE} + h_adj) ^ {7'b0, {3{NL}}};

    // Position inside the current tile, horizontally and vertically
    assign phase = sh[2:0];
    assign row   = sv[2:0];

    // Marks the pixel where the graphics fetch for the new tile starts
    assign code_strobe = CE_PIX && (phase == PH_FETCH);

    // ==============================
    // Tile-map address
    // ==============================

    // The address is taken once per tile at the first pixel phase.
    // The wide map uses the extra horizontal bit, the narrow one
    // pads the top with zero and wraps after 64 columns
    always_ff @(posedge CLK_32M) begin
        if (!rst_n) begin
            tile_index <= '0;
        end else if (CE_PIX && (phase == PH_INDEX)) begin
            if (wide) begin
                tile_index <= {sv[8:3], sh[9:3]};
            end else begin
                tile_index <= {1'b0, sv[8:3], sh[8:3]};
            end
        end
    end

endmodule

// ==== hdl/tile_gfx_fetch.sv ====
/* Graphics row fetch for one tile: ROM address build, SDRAM
   valid/ready request FSM, row capture and late-row flag */

`timescale 1ns/10ps

module tile_gfx_fetch (
    input  logic                     CLK_32M,
    input  logic                     rst_n,
    input  logic                     CE_PIX,
    input  logic [2:0]               phase,
    input  logic                     code_strobe,
    input  logic [2:0]               row,
    input  bg_layer_pkg::tile_word_t tile_data,
    output bg_layer_pkg::gfx_addr_t  sdr_addr,
    output logic                     sdr_req,
    input  logic                     sdr_ack,
    input  bg_layer_pkg::gfx_row_t   sdr_data,
    input  logic                     sdr_rdy,
    output bg_layer_pkg::gfx_row_t   rom_row,
    output logic                     load,
    output logic                     gfx_late
);

    import bg_layer_pkg::*;

    fetch_state_t state;
    // Set once the row for the current tile has been captured
    logic         fresh;
    // Row inside the tile after vertical flip
    logic [2:0]   rv;
    logic         start;

    assign rv    = row ^ {3{tile_data[VFLIP_BIT]}};
    assign start = (state == IDLE) && code_strobe;

    // Last pixel of the tile, the shifter and attributes take over here
    assign load = CE_PIX && (phase == PH_LOAD);

    // ==============================
    // Request FSM
    // ==============================

    always_ff @(posedge CLK_32M) begin
        if (!rst_n) begin
            state    <= IDLE;
            sdr_req  <= 1'b0;
            fresh    <= 1'b0;
            gfx_late <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (code_strobe) begin
                        state   <= REQ;
                        sdr_req <= 1'b1;
                    end
                end
                // Request is held until the SDRAM side accepts it
                REQ: begin
                    if (sdr_ack) begin
                        state   <= WAIT;
                        sdr_req <= 1'b0;
                    end
                end
                WAIT: begin
                    if (sdr_rdy) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase

            // A row arriving on the load pixel itself is already too late
            if ((state == WAIT) && sdr_rdy && !load) begin
                fresh <= 1'b1;
            end else if (load || start) begin
                fresh <= 1'b0;
            end

            // Late flag holds from the load until the next fetch starts
            if (code_strobe) begin
                gfx_late <= 1'b0;
            end else if (load && !fresh) begin
                gfx_late <= 1'b1;
            end
        end
    end

    // ROM address of the new tile and the row returned for it
    always_ff @(posedge CLK_32M) begin
        if (start) begin
            sdr_addr <= {tile_data[15:0], rv, 2'b00};
        end
        if ((state == WAIT) && sdr_rdy) begin
            rom_row <= sdr_data;
        end
    end

endmodule

// ==== hdl/planar_shifter.sv ====
/* Planar to packed pixel conversion with forward and
   mirrored shift chains for the four bit planes */

`timescale 1ns/10ps

module planar_shifter (
    input  logic                   CLK_32M,
    input  logic                   CE_PIX,
    input  logic                   load,
    input  bg_layer_pkg::gfx_row_t rom_row,
    output bg_layer_pkg::pix_t     bits_fwd,
    output bg_layer_pkg::pix_t     bits_rev
);

    import bg_layer_pkg::*;

    // Byte p of the ROM row holds bit plane p of all eight pixels.
    // Leftmost pixel sits in the top bit of each byte
    logic [7:0] plane_fwd [4];
    logic [7:0] plane_rev [4];

    // ==============================
    // Shift chains
    // ==============================

    // The forward chain shifts towards the top bit and the mirrored
    // chain towards the bottom bit, so one of them always presents
    // the next pixel in the wanted order.
    // Load wins over shift on the last pixel of the previous tile
    always_ff @(posedge CLK_32M) begin
        for (int p = 0; p < 4; p++) begin
            if (load) begin
                plane_fwd[p] <= rom_row[8*p +: 8];
                plane_rev[p] <= rom_row[8*p +: 8];
            end else if (CE_PIX) begin
                plane_fwd[p] <= {plane_fwd[p][6:0], 1'b0};
                plane_rev[p] <= {1'b0, plane_rev[p][7:1]};
            end
        end
    end

    // ==============================
    // Pixel taps
    // ==============================

    // One bit from each plane forms the 4-bit colour index.
    // Plane 0 gives the least significant bit
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            bits_fwd[p] = plane_fwd[p][7];
            bits_rev[p] = plane_rev[p][0];
        end
    end

endmodule

// ==== hdl/pixel_attr_stage.sv ====
/* Per-tile attribute latch and the colour, priority and
   palette outputs of the layer */

`timescale 1ns/10ps

module pixel_attr_stage (
    input  logic                     CLK_32M,
    input  logic                     rst_n,
    input  logic                     load,
    input  bg_layer_pkg::tile_word_t tile_data,
    input  logic                     NL,
    input  logic                     enabled,
    input  bg_layer_pkg::pix_t       bits_fwd,
    input  bg_layer_pkg::pix_t       bits_rev,
    output bg_layer_pkg::pix_t       color,
    output logic                     prio,
    output bg_layer_pkg::pal_t       palette
);

    import bg_layer_pkg::*;

    logic cp8;
    logic cp15;
    logic hflip;
    // Cleared until the first tile reaches the shifter
    logic shown;
    pix_t pix_sel;

    // ==============================
    // Attribute latch
    // ==============================

    // Attributes are taken on the same pixel as the shifter load,
    // so colour and palette always describe the same tile
    always_ff @(posedge CLK_32M) begin
        if (!rst_n) begin
            palette <= '0;
            cp8     <= 1'b0;
            cp15    <= 1'b0;
            hflip   <= 1'b0;
            shown   <= 1'b0;
        end else if (load) begin
            palette <= tile_data[PAL_LSB +: $bits(pal_t)];
            cp8     <= tile_data[CP8_BIT];
            cp15    <= tile_data[CP15_BIT];
            hflip   <= tile_data[HFLIP_BIT];
            shown   <= 1'b1;
        end
    end

    // ==============================
    // Pixel outputs
    // ==============================

    // A flipped tile on a flipped screen reads forward again
    assign pix_sel = (hflip ^ NL) ? bits_rev : bits_fwd;

    assign color = (enabled && shown) ? pix_sel : '0;

    // CP15 tiles win over sprites on every opaque pixel,
    // CP8 tiles only on the upper half of the colour range
    always_comb begin
        if (cp15) begin
            prio = |color;
        end else if (cp8) begin
            prio = color[3];
        end else begin
            prio = 1'b0;
        end
    end

endmodule

// ==== hdl/bg_layer.sv ====
/* Background tile layer top: scroll counter, graphics fetch,
   planar shifter and pixel attribute stage */

`timescale 1ns/10ps

module bg_layer (
    input  logic                     CLK_32M,
    input  logic                     rst_n,
    input  logic                     CE_PIX,
    input  logic                     NL,
    input  bg_layer_pkg::beam_t      VE,
    input  bg_layer_pkg::beam_t      HE,
    input  logic                     wide,
    input  bg_layer_pkg::scroll_t    v_adj,
    input  bg_layer_pkg::scroll_t    h_adj,
    input  bg_layer_pkg::tile_word_t tile_data,
    output bg_layer_pkg::tile_idx_t  tile_index,
    output logic                     prio,
    output bg_layer_pkg::pix_t       color,
    output bg_layer_pkg::pal_t       palette,
    input  bg_layer_pkg::gfx_row_t   sdr_data,
    output bg_layer_pkg::gfx_addr_t  sdr_addr,
    output logic                     sdr_req,
    input  logic                     sdr_ack,
    input  logic                     sdr_rdy,
    input  logic                     enabled,
    output logic                     gfx_late
);

    import bg_layer_pkg::*;

    logic [2:0] phase;
    logic [2:0] row;
    logic       code_strobe;
    logic       load;
    gfx_row_t   rom_row;
    pix_t       bits_fwd;
    pix_t       bits_rev;

    // ==============================
    // Tile pipeline
    // ==============================

    // Beam position to tile-map address and pixel phase
    scroll_counter i_scroll_counter (
        .CLK_32M     (CLK_32M),
        .rst_n       (rst_n),
        .CE_PIX      (CE_PIX),
        .NL          (NL),
        .wide        (wide),
        .VE          (VE),
        .HE          (HE),
        .v_adj       (v_adj),
        .h_adj       (h_adj),
        .tile_index  (tile_index),
        .phase       (phase),
        .row         (row),
        .code_strobe (code_strobe)
    );

    // Tile word to graphics row through the SDRAM port
    tile_gfx_fetch i_tile_gfx_fetch (
        .CLK_32M     (CLK_32M),
        .rst_n       (rst_n),
        .CE_PIX      (CE_PIX),
        .phase       (phase),
        .code_strobe (code_strobe),
        .row         (row),
        .tile_data   (tile_data),
        .sdr_addr    (sdr_addr),
        .sdr_req     (sdr_req),
        .sdr_ack     (sdr_ack),
        .sdr_data    (sdr_data),
        .sdr_rdy     (sdr_rdy),
        .rom_row     (rom_row),
        .load        (load),
        .gfx_late    (gfx_late)
    );

    planar_shifter i_planar_shifter (
        .CLK_32M  (CLK_32M),
        .CE_PIX   (CE_PIX),
        .load     (load),
        .rom_row  (rom_row),
        .bits_fwd (bits_fwd),
        .bits_rev (bits_rev)
    );

    // Final colour, priority and palette of the layer
    pixel_attr_stage i_pixel_attr_stage (
        .CLK_32M   (CLK_32M),
        .rst_n     (rst_n),
        .load      (load),
        .tile_data (tile_data),
        .NL        (NL),
        .enabled   (enabled),
        .bits_fwd  (bits_fwd),
        .bits_rev  (bits_rev),
        .color     (color),
        .prio      (prio),
        .palette   (palette)
    );

endmodule

// ==== testbench/bg_layer_chk.sv ====
/* Bound checker for the background layer: index, ROM request,
   pixel order, priority, enable, late-row and reset rules */

`timescale 1ns/10ps

module bg_layer_chk (
    input logic                     CLK_32M,
    input logic                     rst_n,
    input logic                     CE_PIX,
    input logic                     NL,
    input logic                     wide,
    input logic                     enabled,
    input bg_layer_pkg::beam_t      VE,
    input bg_layer_pkg::beam_t      HE,
    input bg_layer_pkg::scroll_t    v_adj,
    input bg_layer_pkg::scroll_t    h_adj,
    input bg_layer_pkg::tile_word_t tile_data,
    input bg_layer_pkg::tile_idx_t  tile_index,
    input bg_layer_pkg::gfx_addr_t  sdr_addr,
    input logic                     sdr_req,
    input logic                     sdr_ack,
    input bg_layer_pkg::gfx_row_t   sdr_data,
    input logic                     sdr_rdy,
    input bg_layer_pkg::pix_t       color,
    input logic                     prio,
    input bg_layer_pkg::pal_t       palette,
    input logic                     gfx_late
);

    import bg_layer_pkg::*;

    scroll_t    sv;
    scroll_t    sh;
    logic [2:0] ph;
    logic       ld;
    tile_idx_t  exp_idx;
    tile_idx_t  idx_q;
    logic       idx_due;
    gfx_addr_t  exp_addr;
    gfx_addr_t  addr_q;
    logic       req_d;
    // Set while a returned row is waiting for its load pixel
    logic       fresh;
    gfx_row_t   row_c;
    gfx_row_t   shown_row;
    tile_word_t attr;
    logic [2:0] pos;
    logic       valid;
    pix_t       fwd;
    pix_t       rev;
    pix_t       exp_col;
    logic       exp_prio;
    int         err_cnt = 0;

    // ==============================
    // Reference coordinates
    // ==============================

    assign sv = {1'b0, VE} + v_adj;
    assign sh = ({1'b0, HE} + h_adj) ^ {7'b0, {3{NL}}};
    assign ph = sh[2:0];
    assign ld = CE_PIX && (ph == PH_LOAD);

    // Narrow map drops the top column bit and pads with zero
    assign exp_idx  = wide ? {sv[8:3], sh[9:3]} : {1'b0, sv[8:3], sh[8:3]};
    assign exp_addr = {tile_data[15:0], sv[2:0] ^ {3{tile_data[VFLIP_BIT]}}, 2'b00};

    // Pixel pos of the shown row, leftmost pixel in the top bit of each plane
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            fwd[p] = shown_row[8*p + 7 - pos];
            rev[p] = shown_row[8*p + pos];
        end
        exp_col = (attr[HFLIP_BIT] ^ NL) ? rev : fwd;
        if (attr[CP15_BIT]) begin
            exp_prio = |color;
        end else if (attr[CP8_BIT]) begin
            exp_prio = color[3];
        end else begin
            exp_prio = 1'b0;
        end
    end

    // ==============================
    // Delayed tile word and row
    // ==============================

    always_ff @(posedge CLK_32M) begin
        idx_q  <= exp_idx;
        addr_q <= exp_addr;
        if (sdr_rdy) begin
            row_c <= sdr_data;
        end
        if (!rst_n) begin
            idx_due <= 1'b0;
            req_d   <= 1'b0;
            fresh   <= 1'b0;
            attr    <= '0;
            pos     <= '0;
            valid   <= 1'b0;
        end else begin
            idx_due <= CE_PIX && (ph == PH_INDEX);
            req_d   <= sdr_req;
            // A row that lands on the load pixel counts as late
            if (sdr_rdy && !ld) begin
                fresh <= 1'b1;
            end else if (ld || (sdr_req && !req_d)) begin
                fresh <= 1'b0;
            end
            if (ld) begin
                attr      <= tile_data;
                shown_row <= row_c;
                pos       <= '0;
                valid     <= fresh;
            end else if (CE_PIX && valid) begin
                pos   <= pos + 3'd1;
                valid <= (pos != 3'd7);
            end
        end
    end

    // ==============================
    // Assertions
    // ==============================

    a_index: assert property (@(posedge CLK_32M) disable iff (!rst_n)
        idx_due |-> tile_index == idx_q)
    else begin
        err_cnt++;
        $error("ERR %0t tile_index exp %h got %h", $time,
               $sampled(idx_q), $sampled(tile_index));
    end

    a_addr: assert property (@(posedge CLK_32M) disable iff (!rst_n)
        $rose(sdr_req) |-> sdr_addr == addr_q)
    else begin
        err_cnt++;
        $error("ERR %0t sdr_addr exp %h got %h", $time,
               $sampled(addr_q), $sampled(sdr_addr));
    end

    // Back-pressure must not change the pending request
    a_hold: assert property (@(posedge CLK_32M) disable iff (!rst_n)
        sdr_req && !sdr_ack |=> sdr_req && $stable(sdr_addr))
    else begin
        err_cnt++;
        $error("Request dropped or changed while sdr_ack was low at %0t", $time);
    end

    a_color: assert property (@(posedge CLK_32M) disable iff (!rst_n)
        valid && enabled |-> color == exp_col)
    else begin
        err_cnt++;
        $error("ERR %0t color exp %h got %h", $time,
               $sampled(exp_col), $sampled(color));
    end

    a_prio: assert property (@(posedge CLK_32M) disable iff (!rst_n)
        prio == exp_prio && palette == attr[PAL_LSB +: 7])
    else begin
        err_cnt++;
        $error("ERR %0t prio/palette exp %b/%h got %b/%h", $time,
               $sampled(exp_prio), $sampled(attr[PAL_LSB +: 7]),
               $sampled(prio), $sampled(palette));
    end

    a_off: assert property (@(posedge CLK_32M) disable iff (!rst_n)
        !enabled |-> color == '0 && !prio)
    else begin
        err_cnt++;
        $error("ERR %0t color exp 0 got %h with layer disabled", $time,
               $sampled(color));
    end

    a_late: assert property (@(posedge CLK_32M) disable iff (!rst_n)
        ld && !fresh |=> gfx_late)
    else begin
        err_cnt++;
        $error("ERR %0t gfx_late exp 1 got %b", $time, $sampled(gfx_late));
    end

    a_reset: assert property (@(posedge CLK_32M)
        !rst_n |=> !sdr_req && color == '0 && !prio && !gfx_late)
    else begin
        err_cnt++;
        $error("Outputs not cleared after reset at %0t", $time);
    end

endmodule

// ==== testbench/tb_bg_layer.sv ====
/* Testbench for the background layer: clock, reset, beam counters,
   tile-map and SDRAM models, watchdog and result line */

`timescale 1ns/10ps

module tb_bg_layer;

    import bg_layer_pkg::*;

    localparam int FRAMES   = 4;
    localparam int LINES    = 16;
    localparam int LINE_LEN = 128;
    // One pixel takes four clocks of 8 ns
    localparam longint RUN_NS = longint'(FRAMES) * LINES * LINE_LEN * 32;

    logic       CLK_32M;
    logic       rst_n;
    logic       CE_PIX;
    logic       NL;
    logic       wide;
    logic       enabled;
    beam_t      VE;
    beam_t      HE;
    scroll_t    v_adj;
    scroll_t    h_adj;
    tile_word_t tile_data;
    tile_idx_t  tile_index;
    logic       prio;
    pix_t       color;
    pal_t       palette;
    gfx_row_t   sdr_data;
    gfx_addr_t  sdr_addr;
    logic       sdr_req;
    logic       sdr_ack;
    logic       sdr_rdy;
    logic       gfx_late;
    logic       late_d;
    int         late_cnt;
    int         errs;
    logic [31:0] stim_seed = 32'h23eb;
    logic [31:0] sdr_seed  = 32'h23eb;

    bg_layer i_bg_layer (
        .CLK_32M    (CLK_32M),
        .rst_n      (rst_n),
        .CE_PIX     (CE_PIX),
        .NL         (NL),
        .VE         (VE),
        .HE         (HE),
        .wide       (wide),
        .v_adj      (v_adj),
        .h_adj      (h_adj),
        .tile_data  (tile_data),
        .tile_index (tile_index),
        .prio       (prio),
        .color      (color),
        .palette    (palette),
        .sdr_data   (sdr_data),
        .sdr_addr   (sdr_addr),
        .sdr_req    (sdr_req),
        .sdr_ack    (sdr_ack),
        .sdr_rdy    (sdr_rdy),
        .enabled    (enabled),
        .gfx_late   (gfx_late)
    );

    bind bg_layer bg_layer_chk i_bg_layer_chk (.*);

    // LCG step, the stimulus and the SDRAM model each keep their own state
    function automatic logic [31:0] next_rand(inout logic [31:0] state);
        state = state * 32'd1664525 + 32'd1013904223;
        return state;
    endfunction

    // Tile-map contents, a hash of the whole word address
    function automatic tile_word_t map_word(tile_idx_t idx);
        logic [31:0] h;
        h = {19'b0, idx} * 32'h9e37_79b1;
        return h ^ (h >> 13);
    endfunction

    // Graphics ROM contents as a fixed function of the byte address
    function automatic gfx_row_t rom_word(gfx_addr_t a);
        return ({11'b0, a} * 32'h0100_0193) ^ 32'ha5c3_5a3c;
    endfunction

    assign tile_data = map_word(tile_index);

    initial begin
        CLK_32M = 1'b0;
        forever #4 CLK_32M = ~CLK_32M;
    end

    // ==============================
    // SDRAM model
    // ==============================

    // Random ack gap gives back-pressure, the long delays give late rows
    initial begin
        logic [31:0] r;
        gfx_addr_t   addr;
        sdr_ack  = 1'b0;
        sdr_rdy  = 1'b0;
        sdr_data = '0;
        forever begin
            @(posedge CLK_32M);
            if (rst_n && sdr_req) begin
                r = next_rand(sdr_seed);
                repeat (r[1:0]) @(posedge CLK_32M);
                sdr_ack <= 1'b1;
                @(posedge CLK_32M);
                addr = sdr_addr;
                sdr_ack <= 1'b0;
                repeat (1 + r[7:4]) @(posedge CLK_32M);
                sdr_rdy  <= 1'b1;
                sdr_data <= rom_word(addr);
                @(posedge CLK_32M);
                sdr_rdy <= 1'b0;
            end
        end
    end

    always @(posedge CLK_32M) begin
        late_d <= gfx_late;
        if (rst_n && gfx_late && !late_d) begin
            late_cnt++;
        end
    end

    // ==============================
    // Beam and stimulus
    // ==============================

    initial begin
        logic [31:0] r;
        rst_n    = 1'b0;
        CE_PIX   = 1'b0;
        NL       = 1'b0;
        wide     = 1'b0;
        enabled  = 1'b1;
        VE       = '0;
        HE       = '0;
        v_adj    = '0;
        h_adj    = '0;
        late_d   = 1'b0;
        late_cnt = 0;
        repeat (2) @(posedge CLK_32M);
        rst_n <= 1'b1;
        for (int f = 0; f < FRAMES; f++) begin
            // Screen flip, map width and scroll change once per frame
            r = next_rand(stim_seed);
            @(posedge CLK_32M);
            CE_PIX <= 1'b0;
            NL     <= r[0];
            wide   <= r[1];
            v_adj  <= r[17:8];
            h_adj  <= r[29:20];
            for (int ln = 0; ln < LINES; ln++) begin
                r = next_rand(stim_seed);
                for (int px = 0; px < LINE_LEN; px++) begin
                    @(posedge CLK_32M);
                    if (px == 0) begin
                        VE      <= beam_t'(ln);
                        enabled <= (r[2:0] != 3'd0);
                    end
                    HE     <= beam_t'(px);
                    CE_PIX <= 1'b0;
                    repeat (2) @(posedge CLK_32M);
                    @(posedge CLK_32M);
                    CE_PIX <= 1'b1;
                end
            end
        end
        @(posedge CLK_32M);
        CE_PIX <= 1'b0;
        repeat (40) @(posedge CLK_32M);
        errs = i_bg_layer.i_bg_layer_chk.err_cnt;
        $display("Errors: %0d assertion failures, %0d late graphics rows", errs, late_cnt);
        if (errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog sized from the frame length plus a margin
    initial begin
        #(RUN_NS + 20000);
        $display("Watchdog expired before the frames were complete");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== flist.f ====
hdl/bg_layer_pkg.sv
hdl/scroll_counter.sv
hdl/tile_gfx_fetch.sv
hdl/planar_shifter.sv
hdl/pixel_attr_stage.sv
hdl/bg_layer.sv
testbench/bg_layer_chk.sv
testbench/tb_bg_layer.sv

// ==== Bender.yml ====
package:
  name: bg_layer

sources:
  # RTL of the background tile layer
  - hdl/bg_layer_pkg.sv
  - hdl/scroll_counter.sv
  - hdl/tile_gfx_fetch.sv
  - hdl/planar_shifter.sv
  - hdl/pixel_attr_stage.sv
  - hdl/bg_layer.sv

  # Testbench and bound checker
  - target: simulation
    files:
      - testbench/bg_layer_chk.sv
      - testbench/tb_bg_layer.sv
